// File: verilog/des_lin_pkg.sv
package des_lin_pkg;

    // host command codes, full cmd port width
    typedef enum logic [31:0] {
        CMD_SEED     = 32'd1,  // lfsr seed / plaintext upper bits
        CMD_POLY     = 32'd2,  // galois taps
        CMD_MASK_IN  = 32'd3,
        CMD_MASK_OUT = 32'd4,
        CMD_START    = 32'd5,
        CMD_RESTART  = 32'd6
    } cmd_code_e;

    // configuration of one run
    typedef struct packed {
        logic [63:0] seed;
        logic [63:0] poly;
        logic [63:0] mask_in;   // applied to plaintext
        logic [63:0] mask_out;  // applied to ciphertext
    } lin_cfg_t;

    // one 64-bit cipher block, left is the upper word
    typedef struct packed {
        logic [31:0] left;
        logic [31:0] right;
    } block_t;

    // one block in flight through the datapath
    typedef struct packed {
        logic   valid;
        logic   last;  // final sample of the run
        block_t blk;
    } sample_t;

endpackage

// File: verilog/cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl import des_lin_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] cmd,
    input  logic        cmd_valid,   // from host clock domain
    input  logic [31:0] data_upper,
    input  logic [31:0] data_lower,
    input  logic        done,        // run drained, from bias counter
    output logic        cmd_read,
    output lin_cfg_t    cfg,
    output logic        start,       // one cycle
    output logic        restart      // level, whole restart state
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_SEED,
        S_POLY,
        S_MASK_IN,
        S_MASK_OUT,
        S_START_WAIT,  // start seen, wait for host to drop cmd_valid
        S_START,
        S_RUN,
        S_FINISH,
        S_RESTART
    } state_e;

    state_e    state_q, state_d;
    cmd_code_e code;
    logic      valid_meta;
    logic      cmd_valid_sync;

    assign code = cmd_code_e'(cmd);

    // two-flop sync of cmd_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_meta     <= 1'b0;
            cmd_valid_sync <= 1'b0;
        end else begin
            valid_meta     <= cmd_valid;
            cmd_valid_sync <= valid_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) state_q <= S_IDLE;
        else        state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;  // hold by default
        case (state_q)
            S_IDLE: begin
                if (cmd_valid_sync) begin
                    case (code)
                        CMD_SEED:     state_d = S_SEED;
                        CMD_POLY:     state_d = S_POLY;
                        CMD_MASK_IN:  state_d = S_MASK_IN;
                        CMD_MASK_OUT: state_d = S_MASK_OUT;
                        CMD_START:    state_d = S_START_WAIT;
                        CMD_RESTART:  state_d = S_RESTART;
                        default:      state_d = S_IDLE;  // unknown code dropped
                    endcase
                end
            end
            S_SEED, S_POLY, S_MASK_IN, S_MASK_OUT: begin
                if (!cmd_valid_sync) state_d = S_IDLE;
            end
            S_START_WAIT: if (!cmd_valid_sync) state_d = S_START;
            S_START:      state_d = S_RUN;
            S_RUN, S_FINISH: begin
                if (state_q == S_RUN && done) state_d = S_FINISH;
                // only restart is honoured once a run is launched
                if (cmd_valid_sync && code == CMD_RESTART) state_d = S_RESTART;
            end
            S_RESTART: if (!cmd_valid_sync) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    assign cmd_read = state_q inside {S_SEED, S_POLY, S_MASK_IN, S_MASK_OUT,
                                      S_START_WAIT, S_RESTART};
    assign start    = (state_q == S_START);
    assign restart  = (state_q == S_RESTART);

    // config words follow the data bus for every cycle of a load state
    always_ff @(posedge clk) begin
        case (state_q)
            S_SEED:     cfg.seed     <= {data_upper, data_lower};
            S_POLY:     cfg.poly     <= {data_upper, data_lower};
            S_MASK_IN:  cfg.mask_in  <= {data_upper, data_lower};
            S_MASK_OUT: cfg.mask_out <= {data_upper, data_lower};
            default: ;
        endcase
    end

endmodule

// File: verilog/sample_lfsr.sv
`timescale 1ns/1ps

module sample_lfsr import des_lin_pkg::*; #(
    parameter int N = 8  // lfsr width, 2..32
) (
    input  logic     clk,
    input  logic     rst_n,
    input  lin_cfg_t cfg,
    input  logic     start,
    input  logic     restart,
    output sample_t  smp
);

    localparam logic [N-1:0] ONE = {{(N-1){1'b0}}, 1'b1};

    logic [N-1:0] lfsr_q;
    logic [N-1:0] lfsr_next;
    logic [N-1:0] remain_q;  // samples still to issue, 2^N-1 fits in N bits

    // galois step, shift right and fold taps in on a set lsb
    assign lfsr_next = (lfsr_q >> 1) ^ (lfsr_q[0] ? cfg.poly[N-1:0] : '0);

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            remain_q  <= '0;
            smp.valid <= 1'b0;
            smp.last  <= 1'b0;
        end else if (start) begin
            remain_q  <= '1;
            smp.valid <= 1'b0;
            smp.last  <= 1'b0;
        end else begin
            smp.valid <= (remain_q != '0);
            smp.last  <= (remain_q == ONE);  // final of the run
            if (remain_q != '0) remain_q <= remain_q - ONE;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (start) lfsr_q <= cfg.seed[N-1:0];
        else       lfsr_q <= lfsr_next;
        smp.blk <= {cfg.seed[63:N], lfsr_q};  // seed upper bits, lfsr low
    end

endmodule

// File: verilog/feistel_pipe.sv
`timescale 1ns/1ps

module feistel_pipe import des_lin_pkg::*; #(
    parameter int                   ROUNDS     = 4,
    parameter logic [ROUNDS*32-1:0] ROUND_KEYS = '0  // round r at [32r+31:32r]
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    restart,
    input  sample_t smp_in,
    output sample_t smp_out
);

    genvar r;

    // one register stage per round, no final swap
    for (r = 0; r < ROUNDS; r++) begin : g_round
        sample_t     src;    // stage input
        sample_t     q;      // stage register
        logic [31:0] f_out;  // linear round function

        if (r == 0) begin : g_first
            assign src = smp_in;
        end else begin : g_chain
            assign src = g_round[r-1].q;
        end

        // rotl 3 then key, stands in for the s-boxes
        assign f_out = {src.blk.right[28:0], src.blk.right[31:29]}
                     ^ ROUND_KEYS[32*r +: 32];

        always_ff @(posedge clk) begin
            q.blk.left  <= src.blk.right;
            q.blk.right <= src.blk.left ^ f_out;
            if (!rst_n || restart) begin  // flush in-flight samples
                q.valid <= 1'b0;
                q.last  <= 1'b0;
            end else begin
                q.valid <= src.valid;
                q.last  <= src.last;
            end
        end
    end

    assign smp_out = g_round[ROUNDS-1].q;  // latency ROUNDS

endmodule

// File: verilog/input_parity_pipe.sv
`timescale 1ns/1ps

module input_parity_pipe import des_lin_pkg::*; #(
    parameter int ROUNDS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        restart,
    input  sample_t     smp_in,
    input  logic [63:0] mask_in,
    output logic        par_out  // aligned with feistel_pipe output
);

    logic              par;
    logic [ROUNDS-1:0] par_q;  // delay line, one tap per round

    assign par = smp_in.valid & (^(smp_in.blk & mask_in));  // <mask, pt>

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            par_q <= '0;
        end else begin
            par_q[0] <= par;
            for (int i = 1; i < ROUNDS; i++) par_q[i] <= par_q[i-1];
        end
    end

    assign par_out = par_q[ROUNDS-1];

endmodule

// File: verilog/bias_counter.sv
`timescale 1ns/1ps

module bias_counter import des_lin_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        restart,
    input  sample_t     smp,       // ciphertext sample
    input  logic        par_in,    // plaintext parity, same cycle
    input  logic [63:0] mask_out,
    output logic [63:0] counter,   // matches of the run
    output logic        done
);

    logic out_par;
    logic match;

    assign out_par = ^(smp.blk & mask_out);
    // linear approximation holds when both parities agree
    assign match   = smp.valid && (out_par == par_in);

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            counter <= '0;
            done    <= 1'b0;
        end else begin
            if (match && !done) counter <= counter + 64'd1;
            // last sample counted on this edge, done follows it
            if (smp.valid && smp.last) done <= 1'b1;  // sticky till restart
        end
    end

endmodule

// File: verilog/des_linear_top.sv
`timescale 1ns/1ps

module des_linear_top import des_lin_pkg::*; #(
    parameter int                   N          = 8,   // lfsr width, 2..32
    parameter int                   ROUNDS     = 4,   // 1..16
    parameter logic [ROUNDS*32-1:0] ROUND_KEYS = {ROUNDS{32'h5a3c_96e1}}
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] cmd,
    input  logic        cmd_valid,
    input  logic [31:0] data_upper,
    input  logic [31:0] data_lower,
    output logic        cmd_read,
    output logic        done,
    output logic [63:0] counter
);

    lin_cfg_t cfg;
    logic     start;
    logic     restart;
    sample_t  pt_smp;  // plaintext, feeds both paths
    sample_t  ct_smp;  // ciphertext
    logic     in_par;

    cmd_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .data_upper (data_upper),
        .data_lower (data_lower),
        .done       (done),
        .cmd_read   (cmd_read),
        .cfg        (cfg),
        .start      (start),
        .restart    (restart)
    );

    sample_lfsr #(.N(N)) u_lfsr (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .start   (start),
        .restart (restart),
        .smp     (pt_smp)
    );

    feistel_pipe #(.ROUNDS(ROUNDS), .ROUND_KEYS(ROUND_KEYS)) u_cipher (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (restart),
        .smp_in  (pt_smp),
        .smp_out (ct_smp)
    );

    input_parity_pipe #(.ROUNDS(ROUNDS)) u_in_par (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (restart),
        .smp_in  (pt_smp),
        .mask_in (cfg.mask_in),
        .par_out (in_par)
    );

    // ciphertext parity taken under mask_out
    bias_counter u_bias (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .smp      (ct_smp),
        .par_in   (in_par),
        .mask_out (cfg.mask_out),
        .counter  (counter),
        .done     (done)
    );

endmodule

// File: tb/des_lin_chk.sv
`timescale 1ns/1ps

module des_lin_chk import des_lin_pkg::*; #(
    parameter int                   N          = 8,
    parameter int                   ROUNDS     = 4,
    parameter logic [ROUNDS*32-1:0] ROUND_KEYS = '0
) (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] cmd,
    input logic        cmd_valid,
    input logic [31:0] data_upper,
    input logic [31:0] data_lower,
    input logic        cmd_read,
    input logic        done,
    input logic [63:0] counter
);

    int unsigned err_cnt = 0;  // watched by tb_top
    logic [63:0] seed_m  = '0;
    logic [63:0] poly_m  = '0;
    logic [63:0] mi_m    = '0;
    logic [63:0] mo_m    = '0;
    logic [63:0] exp_cnt = '0;  // model count of the current run
    logic        read_q  = 1'b0;
    logic        code_ok;

    assign code_ok = cmd inside {CMD_SEED, CMD_POLY, CMD_MASK_IN, CMD_MASK_OUT,
                                 CMD_START, CMD_RESTART};

    // walk all lfsr plaintexts, encipher, compare parities
    function automatic logic [63:0] model_count(input logic [63:0] seed, poly, mi, mo);
        logic [63:0]     low;
        logic [63:0]     s;
        logic [63:0]     pt;
        logic [31:0]     l;
        logic [31:0]     r;
        logic [31:0]     t;
        logic [63:0]     cnt;
        longint unsigned total;
        low   = (64'd1 << N) - 64'd1;
        total = (64'd1 << N) - 64'd1;  // 2^N-1 samples
        s     = seed & low;
        cnt   = '0;
        for (longint unsigned i = 0; i < total; i++) begin
            pt = (seed & ~low) | s;
            l  = pt[63:32];
            r  = pt[31:0];
            for (int k = 0; k < ROUNDS; k++) begin
                t = l ^ {r[28:0], r[31:29]} ^ ROUND_KEYS[32*k +: 32];
                l = r;
                r = t;
            end
            if ((^(pt & mi)) == (^({l, r} & mo))) cnt++;
            s = (s >> 1) ^ (s[0] ? (poly & low) : 64'd0);  // galois step
        end
        return cnt;
    endfunction

    // capture config on the first cycle of each accepted command
    always @(posedge clk) begin
        read_q <= cmd_read;
        if (cmd_read && !read_q) begin
            case (cmd)
                CMD_SEED:     seed_m  <= {data_upper, data_lower};
                CMD_POLY:     poly_m  <= {data_upper, data_lower};
                CMD_MASK_IN:  mi_m    <= {data_upper, data_lower};
                CMD_MASK_OUT: mo_m    <= {data_upper, data_lower};
                CMD_START:    exp_cnt <= model_count(seed_m, poly_m, mi_m, mo_m);
                default: ;
            endcase
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |=> !cmd_read && !done && counter == '0)
        else begin
            err_cnt++;
            $error("FAIL %0t cmd_read,done,counter got %0b,%0b,%0d expected 0,0,0",
                   $time, cmd_read, done, counter);
        end

    // sync is two flops, state one more
    a_read_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_valid) && code_ok |-> ##3 cmd_read)
        else begin err_cnt++; $error("FAIL %0t cmd_read got 0 expected 1", $time); end

    a_read_unknown: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !code_ok |=> !cmd_read)
        else begin err_cnt++; $error("FAIL %0t cmd_read got 1 expected 0", $time); end

    a_read_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cmd_valid) |-> ##3 !cmd_read)
        else begin err_cnt++; $error("FAIL %0t cmd_read got 1 expected 0", $time); end

    a_count: assert property (@(posedge clk) disable iff (!rst_n) done |-> counter == exp_cnt)
        else begin
            err_cnt++;
            $error("FAIL %0t counter got %0d expected %0d", $time, counter, exp_cnt);
        end

    // zero masks, every parity pair agrees
    a_zero_mask: assert property (@(posedge clk) disable iff (!rst_n)
        done && mi_m == '0 && mo_m == '0 |-> counter == (64'd1 << N) - 64'd1)
        else begin
            err_cnt++;
            $error("FAIL %0t counter got %0d expected %0d", $time, counter,
                   (64'd1 << N) - 64'd1);
        end

    a_restart: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_read && cmd == CMD_RESTART |=> !done && counter == '0)
        else begin
            err_cnt++;
            $error("FAIL %0t done,counter got %0b,%0d expected 0,0", $time, done, counter);
        end

endmodule

bind des_linear_top des_lin_chk #(
    .N          (N),
    .ROUNDS     (ROUNDS),
    .ROUND_KEYS (ROUND_KEYS)
) u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .data_upper (data_upper),
    .data_lower (data_lower),
    .cmd_read   (cmd_read),
    .done       (done),
    .counter    (counter)
);

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import des_lin_pkg::*; ();

    localparam int                   N      = 8;
    localparam int                   ROUNDS = 4;
    localparam logic [ROUNDS*32-1:0] KEYS   = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
    localparam logic [63:0]          POLY   = 64'hb8;  // maximal taps for N=8

    logic        clk;
    logic        rst_n;
    logic [31:0] cmd;
    logic        cmd_valid;
    logic [31:0] data_upper;
    logic [31:0] data_lower;
    logic        cmd_read;
    logic        done;
    logic [63:0] counter;

    des_linear_top #(.N(N), .ROUNDS(ROUNDS), .ROUND_KEYS(KEYS)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    // first assertion failure in the bound checker ends the run
    always @(negedge clk) begin
        if (dut.u_chk.err_cnt != 0) abort_run("checker assertion failed");
    end

    task automatic wait_read(input logic level);
        int cycles;
        cycles = 0;
        while (cmd_read !== level) begin
            @(negedge clk);  // away from the driving edge
            cycles++;
            if (cycles > 16) abort_run($sformatf("cmd_read never went to %0b", level));
        end
    endtask

    task automatic send_cmd(input logic [31:0] code, input logic [63:0] data);
        @(posedge clk);
        cmd        <= code;
        data_upper <= data[63:32];
        data_lower <= data[31:0];
        cmd_valid  <= 1'b1;
        wait_read(1'b1);
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_read(1'b0);
    endtask

    // unknown code, cmd_read must stay low
    task automatic send_unknown(input logic [31:0] code);
        @(posedge clk);
        cmd       <= code;
        cmd_valid <= 1'b1;
        repeat (8) @(posedge clk);
        cmd_valid <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic load_cfg(input logic [63:0] seed, mi, mo);
        send_cmd(CMD_SEED, seed);
        send_cmd(CMD_POLY, POLY);
        send_cmd(CMD_MASK_IN, mi);
        send_cmd(CMD_MASK_OUT, mo);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > (1 << N) + ROUNDS + 64) abort_run("done never rose after start");
        end
    endtask

    initial begin
        void'($urandom(32'h95f6a119));  // one seed for the whole run
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        data_upper = '0;
        data_lower = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        send_unknown(32'h0000_00a7);
        send_unknown(32'h0);
        repeat (3) begin  // random seeds and masks
            load_cfg({$urandom, $urandom}, {$urandom, $urandom}, {$urandom, $urandom});
            send_cmd(CMD_START, '0);
            wait_done();
            send_cmd(CMD_RESTART, '0);  // restart after done
        end
        load_cfg({$urandom, $urandom}, '0, '0);
        send_cmd(CMD_START, '0);
        wait_done();
        send_cmd(CMD_RESTART, '0);
        load_cfg({$urandom, $urandom}, {$urandom, $urandom}, {$urandom, $urandom});
        send_cmd(CMD_START, '0);
        repeat (40) @(posedge clk);  // mid run
        send_cmd(CMD_RESTART, '0);
        send_cmd(CMD_START, '0);  // same config again
        wait_done();
        repeat (4) @(posedge clk);
        if (dut.u_chk.err_cnt != 0) begin
            abort_run("checker assertion failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: sim.f
verilog/des_lin_pkg.sv
verilog/cmd_ctrl.sv
verilog/sample_lfsr.sv
verilog/feistel_pipe.sv
verilog/input_parity_pipe.sv
verilog/bias_counter.sv
verilog/des_linear_top.sv
tb/des_lin_chk.sv
tb/tb_top.sv

// File: Makefile
TOP := tb_top

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "no pass line in sim.log"; exit 1)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
